//--- compile.f
src/axis_split_pkg.sv
src/axis_skid_buffer.sv
src/axis_lane_splitter.sv
src/axis_lane_fifo.sv
src/axis_lane_arbiter.sv
src/axis_split_top.sv
testbench/tb_axis_split_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_split_top \
  -f compile.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- src/axis_lane_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axis_lane_arbiter
  import axis_split_pkg::*;
#(
  parameter int  CHANNELS   = 4,
  parameter int  LANE_WIDTH = 16,
  parameter int  ID_WIDTH   = 4,
  localparam int KEEP_WIDTH = LANE_WIDTH / 8,
  localparam int DEST_WIDTH = lane_idx_width(CHANNELS)
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [CHANNELS*LANE_WIDTH-1:0] lane_data,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] lane_keep,
  input  logic [CHANNELS-1:0]            lane_valid,
  input  logic [CHANNELS-1:0]            lane_last,
  input  logic [CHANNELS*ID_WIDTH-1:0]   lane_id,
  output logic [CHANNELS-1:0]            lane_ready,
  output logic [LANE_WIDTH-1:0]          m_data,
  output logic [KEEP_WIDTH-1:0]          m_keep,
  output logic                           m_valid,
  output logic                           m_last,
  output logic [ID_WIDTH-1:0]            m_id,
  output logic [DEST_WIDTH-1:0]          m_dest,
  input  logic                           m_ready
);

  // Output register plus one held grant
  skid_state_e state;
  skid_state_e state_next;

  logic [DEST_WIDTH-1:0] last_grant;
  logic [DEST_WIDTH-1:0] pick;
  logic                  found;
  logic                  take;
  logic                  out_xfer;

  logic [LANE_WIDTH-1:0] hold_data;
  logic [KEEP_WIDTH-1:0] hold_keep;
  logic                  hold_last;
  logic [ID_WIDTH-1:0]   hold_id;
  logic [DEST_WIDTH-1:0] hold_dest;

  // Search starts right after the previous winner
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int k = 0; k < CHANNELS; k++) begin
      idx = (int'(last_grant) + 1 + k) % CHANNELS;
      if (!found && lane_valid[idx]) begin
        found = 1'b1;
        pick  = DEST_WIDTH'(idx);
      end
    end
  end

  // No grant while both slots are taken
  assign take     = found && (state != SKID_FULL);
  assign out_xfer = m_valid && m_ready;
  assign m_valid  = (state != SKID_EMPTY);

  always_comb begin
    lane_ready = '0;
    if (take) begin
      lane_ready[pick] = 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      SKID_EMPTY: if (take) state_next = SKID_ONE;
      SKID_ONE: begin
        if (take && !out_xfer) begin
          state_next = SKID_FULL;
        end else if (!take && out_xfer) begin
          state_next = SKID_EMPTY;
        end
      end
      SKID_FULL: if (out_xfer) state_next = SKID_ONE;
      default: state_next = SKID_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= SKID_EMPTY;
      last_grant <= DEST_WIDTH'(CHANNELS - 1);
    end else begin
      state <= state_next;
      if (take) begin
        last_grant <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Winner goes out directly when the register is free or leaving
    if (take && (state == SKID_EMPTY || (state == SKID_ONE && out_xfer))) begin
      m_data <= lane_data[pick*LANE_WIDTH +: LANE_WIDTH];
      m_keep <= lane_keep[pick*KEEP_WIDTH +: KEEP_WIDTH];
      m_last <= lane_last[pick];
      m_id   <= lane_id[pick*ID_WIDTH +: ID_WIDTH];
      m_dest <= pick;
    end else if (state == SKID_FULL && out_xfer) begin
      m_data <= hold_data;
      m_keep <= hold_keep;
      m_last <= hold_last;
      m_id   <= hold_id;
      m_dest <= hold_dest;
    end
    // Park the grant while the output stalls
    if (take && state == SKID_ONE && !out_xfer) begin
      hold_data <= lane_data[pick*LANE_WIDTH +: LANE_WIDTH];
      hold_keep <= lane_keep[pick*KEEP_WIDTH +: KEEP_WIDTH];
      hold_last <= lane_last[pick];
      hold_id   <= lane_id[pick*ID_WIDTH +: ID_WIDTH];
      hold_dest <= pick;
    end
  end

  // Stalled word and its lane number stay put until taken
  a_hold_out: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable({m_data, m_keep, m_last, m_id, m_dest}));

endmodule

`default_nettype wire

//--- src/axis_lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_lane_fifo #(
  parameter int  LANE_WIDTH = 16,
  parameter int  ID_WIDTH   = 4,
  parameter int  FIFO_DEPTH = 4,
  localparam int KEEP_WIDTH = LANE_WIDTH / 8,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH),
  localparam int WORD_WIDTH = LANE_WIDTH + KEEP_WIDTH + ID_WIDTH + 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [LANE_WIDTH-1:0] in_data,
  input  logic [KEEP_WIDTH-1:0] in_keep,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic                  in_last,
  input  logic [ID_WIDTH-1:0]   in_id,
  output logic [LANE_WIDTH-1:0] out_data,
  output logic [KEEP_WIDTH-1:0] out_keep,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  out_last,
  output logic [ID_WIDTH-1:0]   out_id
);

  // Word plus sideband in one entry
  logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];

  // Extra top bit tells full from empty
  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] rd_ptr;
  // Words currently stored
  logic [ADDR_WIDTH:0] level;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                 (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
  assign level = wr_ptr - rd_ptr;

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= {in_last, in_id, in_keep, in_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry read straight from the array
  assign {out_last, out_id, out_keep, out_data} = mem[rd_ptr[ADDR_WIDTH-1:0]];

  // A write into a full FIFO would push the fill level past the depth
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    level <= FIFO_DEPTH);

endmodule

`default_nettype wire

//--- src/axis_lane_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module axis_lane_splitter #(
  parameter int  CHANNELS   = 4,
  parameter int  LANE_WIDTH = 16,
  parameter int  ID_WIDTH   = 4,
  localparam int KEEP_WIDTH = LANE_WIDTH / 8,
  localparam int DATA_WIDTH = CHANNELS * LANE_WIDTH
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [DATA_WIDTH-1:0]          s_data,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] s_keep,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  logic                           s_last,
  input  logic [ID_WIDTH-1:0]            s_id,
  output logic [DATA_WIDTH-1:0]          lane_data,
  output logic [CHANNELS*KEEP_WIDTH-1:0] lane_keep,
  output logic [CHANNELS-1:0]            lane_valid,
  output logic [CHANNELS-1:0]            lane_last,
  output logic [CHANNELS*ID_WIDTH-1:0]   lane_id,
  input  logic [CHANNELS-1:0]            lane_ready
);

  // Buffered wide beat
  logic [DATA_WIDTH-1:0]          buf_data;
  logic [CHANNELS*KEEP_WIDTH-1:0] buf_keep;
  logic                           buf_valid;
  logic                           buf_ready;
  logic                           buf_last;
  logic [ID_WIDTH-1:0]            buf_id;

  logic [CHANNELS-1:0] has_data;
  logic [CHANNELS-1:0] handshake;
  // Lanes that already took the current beat
  logic [CHANNELS-1:0] lock;

  axis_skid_buffer #(
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_skid (
    .clk    (clk),
    .rst    (rst),
    .s_data (s_data),
    .s_keep (s_keep),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_last (s_last),
    .s_id   (s_id),
    .m_data (buf_data),
    .m_keep (buf_keep),
    .m_valid(buf_valid),
    .m_ready(buf_ready),
    .m_last (buf_last),
    .m_id   (buf_id)
  );

  // Lanes keep the wide packing, so data and keep pass as is
  assign lane_data = buf_data;
  assign lane_keep = buf_keep;
  assign lane_last = {CHANNELS{buf_last}};
  assign lane_id   = {CHANNELS{buf_id}};

  for (genvar i = 0; i < CHANNELS; i++) begin : g_lane
    // Empty keep slice means nothing to hand over
    assign has_data[i]   = |buf_keep[i*KEEP_WIDTH +: KEEP_WIDTH];
    assign lane_valid[i] = buf_valid && !lock[i] && has_data[i];

    // Locked lane belongs to the beat still waiting in the skid buffer
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
      lock[i] |-> buf_valid && has_data[i]);
  end

  assign handshake = lane_valid & lane_ready;

  // Release once every lane with data is done or finishing now
  assign buf_ready = &(~has_data | lock | handshake);

  always_ff @(posedge clk) begin
    if (rst) begin
      lock <= '0;
    end else if (buf_ready) begin
      lock <= '0;
    end else begin
      lock <= lock | handshake;
    end
  end

endmodule

`default_nettype wire

//--- src/axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
  import axis_split_pkg::*;
#(
  parameter int  DATA_WIDTH = 64,
  parameter int  ID_WIDTH   = 4,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] s_data,
  input  logic [KEEP_WIDTH-1:0] s_keep,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic                  s_last,
  input  logic [ID_WIDTH-1:0]   s_id,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic [KEEP_WIDTH-1:0] m_keep,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic                  m_last,
  output logic [ID_WIDTH-1:0]   m_id
);

  skid_state_e state;
  skid_state_e state_next;

  // Second slot, only filled when the output stalls
  logic [DATA_WIDTH-1:0] skid_data;
  logic [KEEP_WIDTH-1:0] skid_keep;
  logic                  skid_last;
  logic [ID_WIDTH-1:0]   skid_id;

  logic in_xfer;
  logic out_xfer;
  logic load_main_in;
  logic load_main_skid;
  logic load_skid;

  assign in_xfer  = s_valid && s_ready;
  assign out_xfer = m_valid && m_ready;
  assign m_valid  = (state != SKID_EMPTY);

  always_comb begin
    state_next     = state;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    case (state)
      SKID_EMPTY: begin
        if (in_xfer) begin
          load_main_in = 1'b1;
          state_next   = SKID_ONE;
        end
      end
      SKID_ONE: begin
        // Pass-through when both sides move
        if (in_xfer && out_xfer) begin
          load_main_in = 1'b1;
        end else if (in_xfer) begin
          load_skid  = 1'b1;
          state_next = SKID_FULL;
        end else if (out_xfer) begin
          state_next = SKID_EMPTY;
        end
      end
      SKID_FULL: begin
        // Input is stalled here, so only the drain matters
        if (out_xfer) begin
          load_main_skid = 1'b1;
          state_next     = SKID_ONE;
        end
      end
      default: state_next = SKID_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SKID_EMPTY;
      s_ready <= 1'b0;
    end else begin
      state   <= state_next;
      // Ready straight from a flop
      s_ready <= (state_next != SKID_FULL);
    end
  end

  always_ff @(posedge clk) begin
    if (load_main_in) begin
      m_data <= s_data;
      m_keep <= s_keep;
      m_last <= s_last;
      m_id   <= s_id;
    end else if (load_main_skid) begin
      m_data <= skid_data;
      m_keep <= skid_keep;
      m_last <= skid_last;
      m_id   <= skid_id;
    end
    if (load_skid) begin
      skid_data <= s_data;
      skid_keep <= s_keep;
      skid_last <= s_last;
      skid_id   <= s_id;
    end
  end

  // Stalled output word must not change under the consumer
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> $stable(m_data));

endmodule

`default_nettype wire

//--- src/axis_split_pkg.sv
`default_nettype none

package axis_split_pkg;

  // Fill level of a two-entry register slice
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,
    SKID_ONE   = 2'd1,
    SKID_FULL  = 2'd2
  } skid_state_e;

  // Bits needed to number the lanes, never below one
  function automatic int lane_idx_width(input int lanes);
    int width;
    width = $clog2(lanes);
    if (width < 1) begin
      width = 1;
    end
    return width;
  endfunction

endpackage

`default_nettype wire

//--- src/axis_split_top.sv
`timescale 1ns/1ps
`default_nettype none

module axis_split_top
  import axis_split_pkg::*;
#(
  parameter int  CHANNELS   = 4,
  parameter int  LANE_WIDTH = 16,
  parameter int  ID_WIDTH   = 4,
  parameter int  FIFO_DEPTH = 4,
  localparam int KEEP_WIDTH = LANE_WIDTH / 8,
  localparam int DEST_WIDTH = lane_idx_width(CHANNELS)
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [CHANNELS*LANE_WIDTH-1:0] s_data,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] s_keep,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  logic                           s_last,
  input  logic [ID_WIDTH-1:0]            s_id,
  output logic [LANE_WIDTH-1:0]          m_data,
  output logic [KEEP_WIDTH-1:0]          m_keep,
  output logic                           m_valid,
  input  logic                           m_ready,
  output logic                           m_last,
  output logic [ID_WIDTH-1:0]            m_id,
  output logic [DEST_WIDTH-1:0]          m_dest
);

  // Splitter to FIFO
  logic [CHANNELS*LANE_WIDTH-1:0] split_data;
  logic [CHANNELS*KEEP_WIDTH-1:0] split_keep;
  logic [CHANNELS-1:0]            split_valid;
  logic [CHANNELS-1:0]            split_ready;
  logic [CHANNELS-1:0]            split_last;
  logic [CHANNELS*ID_WIDTH-1:0]   split_id;

  // FIFO to arbiter
  logic [CHANNELS*LANE_WIDTH-1:0] fifo_data;
  logic [CHANNELS*KEEP_WIDTH-1:0] fifo_keep;
  logic [CHANNELS-1:0]            fifo_valid;
  logic [CHANNELS-1:0]            fifo_ready;
  logic [CHANNELS-1:0]            fifo_last;
  logic [CHANNELS*ID_WIDTH-1:0]   fifo_id;

  axis_lane_splitter #(
    .CHANNELS  (CHANNELS),
    .LANE_WIDTH(LANE_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_splitter (
    .clk       (clk),
    .rst       (rst),
    .s_data    (s_data),
    .s_keep    (s_keep),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_last    (s_last),
    .s_id      (s_id),
    .lane_data (split_data),
    .lane_keep (split_keep),
    .lane_valid(split_valid),
    .lane_last (split_last),
    .lane_id   (split_id),
    .lane_ready(split_ready)
  );

  // One buffer per lane
  for (genvar i = 0; i < CHANNELS; i++) begin : g_fifo
    axis_lane_fifo #(
      .LANE_WIDTH(LANE_WIDTH),
      .ID_WIDTH  (ID_WIDTH),
      .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
      .clk      (clk),
      .rst      (rst),
      .in_data  (split_data[i*LANE_WIDTH +: LANE_WIDTH]),
      .in_keep  (split_keep[i*KEEP_WIDTH +: KEEP_WIDTH]),
      .in_valid (split_valid[i]),
      .in_ready (split_ready[i]),
      .in_last  (split_last[i]),
      .in_id    (split_id[i*ID_WIDTH +: ID_WIDTH]),
      .out_data (fifo_data[i*LANE_WIDTH +: LANE_WIDTH]),
      .out_keep (fifo_keep[i*KEEP_WIDTH +: KEEP_WIDTH]),
      .out_valid(fifo_valid[i]),
      .out_ready(fifo_ready[i]),
      .out_last (fifo_last[i]),
      .out_id   (fifo_id[i*ID_WIDTH +: ID_WIDTH])
    );
  end

  axis_lane_arbiter #(
    .CHANNELS  (CHANNELS),
    .LANE_WIDTH(LANE_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .lane_data (fifo_data),
    .lane_keep (fifo_keep),
    .lane_valid(fifo_valid),
    .lane_last (fifo_last),
    .lane_id   (fifo_id),
    .lane_ready(fifo_ready),
    .m_data    (m_data),
    .m_keep    (m_keep),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_id      (m_id),
    .m_dest    (m_dest),
    .m_ready   (m_ready)
  );

endmodule

`default_nettype wire

//--- testbench/tb_axis_split_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axis_split_top;

  localparam int CHANNELS   = 4;
  localparam int LANE_WIDTH = 16;
  localparam int ID_WIDTH   = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int KEEP_WIDTH = LANE_WIDTH / 8;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_BEATS  = 24;
  // Watchdog budget in clock cycles
  localparam int MAX_CYCLES = NUM_BEATS * 20;
  // Room per lane for every beat of the table
  localparam int LANE_SLOTS = 32;

  logic        clk;
  logic        rst;
  logic [63:0] s_data;
  logic [7:0]  s_keep;
  logic        s_valid;
  logic        s_ready;
  logic        s_last;
  logic [3:0]  s_id;
  logic [15:0] m_data;
  logic [1:0]  m_keep;
  logic        m_valid;
  logic        m_ready;
  logic        m_last;
  logic [3:0]  m_id;
  logic [1:0]  m_dest;

  // Beat row is {last, id, keep, data}
  logic [76:0] beat_tbl [NUM_BEATS];

  // Expected lane words as {last, id, keep, data}
  logic [22:0] exp_word [CHANNELS][LANE_SLOTS];
  int head [CHANNELS];
  int tail [CHANNELS];
  int exp_total;
  int rx_count;

  // Error counts per test
  int err_reset;
  int err_order;
  int err_empty;
  int err_side;
  int err_count;

  logic [7:0] lfsr;

  axis_split_top #(
    .CHANNELS  (CHANNELS),
    .LANE_WIDTH(LANE_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) DUT (
    .clk    (clk),
    .rst    (rst),
    .s_data (s_data),
    .s_keep (s_keep),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_last (s_last),
    .s_id   (s_id),
    .m_data (m_data),
    .m_keep (m_keep),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_last (m_last),
    .m_id   (m_id),
    .m_dest (m_dest)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    logic fb;
    fb = state[7] ^ state[5] ^ state[4] ^ state[3];
    return {state[6:0], fb};
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic load_table();
    beat_tbl = '{
      {1'b0, 4'h1, 8'hFF, 64'h1003_1002_1001_1000},
      {1'b0, 4'h1, 8'hFF, 64'h1103_1102_1101_1100},
      // Upper two lanes empty
      {1'b1, 4'h1, 8'h0F, 64'h1203_1202_1201_1200},
      {1'b0, 4'h2, 8'hF0, 64'h1303_1302_1301_1300},
      {1'b0, 4'h2, 8'h33, 64'h1403_1402_1401_1400},
      {1'b1, 4'h2, 8'hCC, 64'h1503_1502_1501_1500},
      // Partial keep inside one lane
      {1'b0, 4'h3, 8'h01, 64'h1603_1602_1601_1600},
      {1'b0, 4'h3, 8'h80, 64'h1703_1702_1701_1700},
      // No lane at all
      {1'b1, 4'h3, 8'h00, 64'h1803_1802_1801_1800},
      // Full burst to fill the FIFOs
      {1'b0, 4'h4, 8'hFF, 64'h1903_1902_1901_1900},
      {1'b0, 4'h4, 8'hFF, 64'h1A03_1A02_1A01_1A00},
      {1'b0, 4'h4, 8'hFF, 64'h1B03_1B02_1B01_1B00},
      {1'b0, 4'h4, 8'hFF, 64'h1C03_1C02_1C01_1C00},
      {1'b0, 4'h4, 8'hFF, 64'h1D03_1D02_1D01_1D00},
      {1'b0, 4'h4, 8'hFF, 64'h1E03_1E02_1E01_1E00},
      {1'b1, 4'h4, 8'hFF, 64'h1F03_1F02_1F01_1F00},
      {1'b0, 4'h5, 8'h0C, 64'h2003_2002_2001_2000},
      {1'b0, 4'h5, 8'h30, 64'h2103_2102_2101_2100},
      {1'b0, 4'h5, 8'hC3, 64'h2203_2202_2201_2200},
      {1'b1, 4'h5, 8'h3C, 64'h2303_2302_2301_2300},
      {1'b0, 4'h6, 8'hFF, 64'h2403_2402_2401_2400},
      {1'b0, 4'h6, 8'h5A, 64'h2503_2502_2501_2500},
      {1'b1, 4'h6, 8'hA5, 64'h2603_2602_2601_2600},
      {1'b1, 4'h7, 8'h02, 64'h2703_2702_2701_2700}
    };
  endtask

  // Per lane queues straight from the table
  task automatic build_expected();
    logic [KEEP_WIDTH-1:0] keep_slice;
    exp_total = 0;
    for (int l = 0; l < CHANNELS; l++) begin
      head[l] = 0;
      tail[l] = 0;
    end
    for (int b = 0; b < NUM_BEATS; b++) begin
      for (int l = 0; l < CHANNELS; l++) begin
        keep_slice = beat_tbl[b][64 + KEEP_WIDTH*l +: KEEP_WIDTH];
        // Lane with no keep bits carries nothing
        if (keep_slice != '0) begin
          exp_word[l][tail[l]] = {beat_tbl[b][76], beat_tbl[b][75:72], keep_slice,
                                  beat_tbl[b][LANE_WIDTH*l +: LANE_WIDTH]};
          tail[l]++;
          exp_total++;
        end
      end
    end
  endtask

  // Returns on the edge that takes the beat
  task automatic wait_accept();
    @(negedge clk);
    while (!s_ready) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic check_word();
    int lane;
    logic [22:0] want;
    lane = int'(m_dest);
    rx_count++;
    assert (m_keep != '0) else begin
      report_fail($sformatf("word on lane %0d with empty keep", lane));
      err_empty++;
    end
    assert (head[lane] != tail[lane]) else begin
      report_fail($sformatf("word %h on lane %0d, none expected", m_data, lane));
      err_empty++;
    end
    if (head[lane] != tail[lane]) begin
      want = exp_word[lane][head[lane]];
      head[lane]++;
      assert ({m_keep, m_data} == want[17:0]) else begin
        report_fail($sformatf("lane %0d keep/data %h/%h, expected %h/%h",
                              lane, m_keep, m_data, want[17:16], want[15:0]));
        err_order++;
      end
      assert ({m_last, m_id} == want[22:18]) else begin
        report_fail($sformatf("lane %0d last/id %0b/%h, expected %0b/%h",
                              lane, m_last, m_id, want[22], want[21:18]));
        err_side++;
      end
    end
  endtask

  task automatic check_totals();
    assert (rx_count == exp_total) else begin
      report_fail($sformatf("received %0d words, expected %0d", rx_count, exp_total));
      err_count++;
    end
    for (int l = 0; l < CHANNELS; l++) begin
      assert (head[l] == tail[l]) else begin
        report_fail($sformatf("lane %0d still owes %0d words", l, tail[l] - head[l]));
        err_count++;
      end
    end
  endtask

  // Output sampled mid-cycle, where everything is settled
  always @(negedge clk) begin
    if (!rst && m_valid && m_ready) begin
      check_word();
    end
  end

  // Random back-pressure, one LFSR step per bit
  always @(posedge clk) begin
    if (rst) begin
      m_ready <= 1'b0;
    end else begin
      lfsr = lfsr_step(lfsr);
      m_ready <= lfsr[0];
    end
  end

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int total_err;
    int passed;
    clk       = 1'b0;
    rst       = 1'b1;
    s_data    = '0;
    s_keep    = '0;
    s_valid   = 1'b0;
    s_last    = 1'b0;
    s_id      = '0;
    m_ready   = 1'b0;
    lfsr      = 8'd76;
    rx_count  = 0;
    err_reset = 0;
    err_order = 0;
    err_empty = 0;
    err_side  = 0;
    err_count = 0;
    load_table();
    build_expected();

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // Reset released, no live edge yet
    @(negedge clk);
    assert (!m_valid && !s_ready) else begin
      report_fail($sformatf("after reset m_valid %0b s_ready %0b", m_valid, s_ready));
      err_reset++;
    end
    @(negedge clk);
    assert (s_ready) else begin
      report_fail("s_ready still low one cycle after reset");
      err_reset++;
    end
    $display("Test 1 reset state: %s", (err_reset == 0) ? "ok" : "FAILED");

    @(posedge clk);
    for (int b = 0; b < NUM_BEATS; b++) begin
      {s_last, s_id, s_keep, s_data} <= beat_tbl[b];
      s_valid <= 1'b1;
      wait_accept();
    end
    s_valid <= 1'b0;

    // Drain, then watch a while longer for stray words
    while (rx_count < exp_total) @(negedge clk);
    repeat (20) @(negedge clk);
    @(posedge clk);
    check_totals();

    $display("Test 2 lane data order: %s", (err_order == 0) ? "ok" : "FAILED");
    $display("Test 3 empty lanes dropped: %s", (err_empty == 0) ? "ok" : "FAILED");
    $display("Test 4 last and id copied: %s", (err_side == 0) ? "ok" : "FAILED");
    $display("Test 5 word count %0d of %0d: %s", rx_count, exp_total,
             (err_count == 0) ? "ok" : "FAILED");

    total_err = err_reset + err_order + err_empty + err_side + err_count;
    passed = int'(err_reset == 0) + int'(err_order == 0) + int'(err_empty == 0) +
             int'(err_side == 0) + int'(err_count == 0);
    $display("Tests run: 5, passed: %0d, failed: %0d, failed checks: %0d",
             passed, 5 - passed, total_err);
    if (total_err == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
